// ==== rtl/ni_cfg.svh ====
/*
  Build-time constants of the AXI slave network interface.
  Widths, queue depths, channel count and the address map.
  Include this wherever a width or a window address is needed.
*/
`ifndef NI_CFG_SVH
`define NI_CFG_SVH

// ********************
// data path and AXI fields
`define NI_DATA_W      32
`define NI_ID_W        4
`define NI_LEN_W       8
`define NI_ADDR_W      16

// ********************
// virtual channels and buffering
`define NI_NUM_VC      2
`define NI_VC_W        1
`define NI_OT_DEPTH    4
`define NI_RXBUF_DEPTH 8

// ********************
// address map, one exact word per channel window
`define NI_WR_VC_BASE  16'h1000
`define NI_RD_VC_BASE  16'h2000
`define NI_VC_STRIDE   8
// beat size code for 4 bytes
`define NI_SIZE_OK     3'd2

`endif

// ==== rtl/ni_pkg.sv ====
/*
  Shared types of the network interface.
  AXI channel bundles, flit bundles, the outstanding-entry record
  and the region / burst / response encodings.
*/
`include "ni_cfg.svh"

package ni_pkg;

  // address classification result
  typedef enum logic [1:0] {
    REGION_NONE  = 2'd0,
    REGION_WR_VC = 2'd1,
    REGION_RD_VC = 2'd2
  } region_t;

  // AXI burst encodings
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_t;

  // only the two responses this slave gives
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  // ********************
  // everything the master drives
  typedef struct packed {
    logic                  awvalid;
    logic [`NI_ID_W-1:0]   awid;
    logic [`NI_ADDR_W-1:0] awaddr;
    logic [`NI_LEN_W-1:0]  awlen;
    logic [2:0]            awsize;
    axi_burst_t            awburst;
    logic                  wvalid;
    logic [`NI_DATA_W-1:0] wdata;
    logic                  wlast;
    logic                  bready;
    logic                  arvalid;
    logic [`NI_ID_W-1:0]   arid;
    logic [`NI_ADDR_W-1:0] araddr;
    logic [`NI_LEN_W-1:0]  arlen;
    logic [2:0]            arsize;
    axi_burst_t            arburst;
    logic                  rready;
  } axi_req_t;

  // everything the slave drives
  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [`NI_ID_W-1:0]   bid;
    axi_resp_t             bresp;
    logic                  arready;
    logic                  rvalid;
    logic [`NI_ID_W-1:0]   rid;
    logic [`NI_DATA_W-1:0] rdata;
    axi_resp_t             rresp;
    logic                  rlast;
  } axi_resp_bus_t;

  // ********************
  // one accepted request, decoded once at address time
  typedef struct packed {
    logic [`NI_ID_W-1:0]  id;
    logic [`NI_LEN_W-1:0] len;
    region_t              region;
    logic [`NI_VC_W-1:0]  vc;
  } ot_entry_t;

  // flit towards the router
  typedef struct packed {
    logic                  valid;
    logic [`NI_VC_W-1:0]   vc;
    logic [`NI_DATA_W-1:0] flit;
  } flit_out_t;

  // flit from the router
  typedef struct packed {
    logic                  valid;
    logic [`NI_VC_W-1:0]   vc;
    logic [`NI_DATA_W-1:0] flit;
  } flit_in_t;

endpackage

// ==== rtl/sync_fifo.sv ====
/*
  Single-clock circular FIFO with full and empty flags.
  data_o always shows the head entry; push on full and pop on empty
  are dropped. Used for request queues and receive buffers.
*/
`timescale 1ns/1ps

module sync_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 8
) (
  input  logic             clk_axi,
  input  logic             arst_axi,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem[rd_ptr];

  // storage, no reset on the payload
  always_ff @(posedge clk_axi) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // pointers wrap at DEPTH, not at a power of two
  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== rtl/mm_region_decode.sv ====
/*
  Address decoder for one AXI address channel.
  Returns the window (write channel, read channel or none) and the
  virtual channel. Non-INCR bursts and narrow beats fall to none.
*/
`timescale 1ns/1ps
`include "ni_cfg.svh"

module mm_region_decode (
  input  logic [`NI_ADDR_W-1:0] addr_i,
  input  ni_pkg::axi_burst_t    burst_i,
  input  logic [2:0]            size_i,
  output ni_pkg::region_t       region_o,
  output logic [`NI_VC_W-1:0]   vc_o
);
  logic xfer_ok;

  // full-width INCR only
  assign xfer_ok = (burst_i == ni_pkg::BURST_INCR) && (size_i == `NI_SIZE_OK);

  always_comb begin
    region_o = ni_pkg::REGION_NONE;
    vc_o     = '0;
    if (xfer_ok) begin
      // exact word match per channel window
      for (int i = 0; i < `NI_NUM_VC; i++) begin
        if (addr_i == `NI_ADDR_W'(`NI_WR_VC_BASE + i * `NI_VC_STRIDE)) begin
          region_o = ni_pkg::REGION_WR_VC;
          vc_o     = `NI_VC_W'(i);
        end
        if (addr_i == `NI_ADDR_W'(`NI_RD_VC_BASE + i * `NI_VC_STRIDE)) begin
          region_o = ni_pkg::REGION_RD_VC;
          vc_o     = `NI_VC_W'(i);
        end
      end
    end
  end

endmodule

// ==== rtl/axi_wr_ctrl.sv ====
/*
  Write side of the AXI slave.
  AW requests are decoded and queued; W beats of the head request
  go out as flits or are drained on error; B leaves in AW order.
*/
`timescale 1ns/1ps
`include "ni_cfg.svh"

module axi_wr_ctrl (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  input  ni_pkg::axi_req_t      axi_req_i,
  output ni_pkg::axi_resp_bus_t wr_resp_o,
  output ni_pkg::flit_out_t     pkt_out_o,
  input  logic                  pkt_out_ready_i
);
  // B queue entry is {id, resp}
  localparam int BQ_W = `NI_ID_W + 2;

  ni_pkg::region_t     aw_region;
  logic [`NI_VC_W-1:0] aw_vc;
  ni_pkg::ot_entry_t   ot_in;
  ni_pkg::ot_entry_t   ot_head;
  logic                ot_full;
  logic                ot_empty;
  logic                aw_hs;
  logic                w_open;
  logic                w_to_noc;
  logic                w_ready;
  logic                w_hs;
  logic                w_last_hs;
  ni_pkg::axi_resp_t   b_result;
  logic [BQ_W-1:0]     b_in;
  logic [BQ_W-1:0]     b_head;
  logic                b_full;
  logic                b_empty;
  logic                b_hs;

  // ********************
  // address channel
  mm_region_decode u_aw_decode (
    .addr_i   (axi_req_i.awaddr),
    .burst_i  (axi_req_i.awburst),
    .size_i   (axi_req_i.awsize),
    .region_o (aw_region),
    .vc_o     (aw_vc)
  );

  assign aw_hs = axi_req_i.awvalid && !ot_full;

  always_comb begin
    ot_in.id     = axi_req_i.awid;
    ot_in.len    = axi_req_i.awlen;
    ot_in.region = aw_region;
    ot_in.vc     = aw_vc;
  end

  // outstanding writes, popped on the wlast beat
  sync_fifo #(
    .DEPTH (`NI_OT_DEPTH),
    .WIDTH ($bits(ni_pkg::ot_entry_t))
  ) u_wr_ot_fifo (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .push_i   (aw_hs),
    .pop_i    (w_last_hs),
    .data_i   (ot_in),
    .data_o   (ot_head),
    .full_o   (ot_full),
    .empty_o  (ot_empty)
  );

  // ********************
  // data channel
  // W opens only with a head request and room for its response
  assign w_open   = !ot_empty && !b_full;
  assign w_to_noc = (ot_head.region == ni_pkg::REGION_WR_VC);

  // good beats pass straight to the router
  always_comb begin
    pkt_out_o.valid = w_open && w_to_noc && axi_req_i.wvalid;
    pkt_out_o.vc    = ot_head.vc;
    pkt_out_o.flit  = axi_req_i.wdata;
  end

  // error beats are swallowed at full rate
  assign w_ready   = w_open && (w_to_noc ? pkt_out_ready_i : 1'b1);
  assign w_hs      = axi_req_i.wvalid && w_ready;
  assign w_last_hs = w_hs && axi_req_i.wlast;

  // ********************
  // response channel
  assign b_result = w_to_noc ? ni_pkg::RESP_OKAY : ni_pkg::RESP_SLVERR;
  assign b_in     = {ot_head.id, b_result};
  assign b_hs     = !b_empty && axi_req_i.bready;

  // bvalid one cycle after the wlast transfer
  sync_fifo #(
    .DEPTH (`NI_OT_DEPTH),
    .WIDTH (BQ_W)
  ) u_wr_b_fifo (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .push_i   (w_last_hs),
    .pop_i    (b_hs),
    .data_i   (b_in),
    .data_o   (b_head),
    .full_o   (b_full),
    .empty_o  (b_empty)
  );

  // aw, w and b fields only
  always_comb begin
    wr_resp_o         = '0;
    wr_resp_o.awready = !ot_full;
    wr_resp_o.wready  = w_ready;
    wr_resp_o.bvalid  = !b_empty;
    wr_resp_o.bid     = b_head[BQ_W-1:2];
    wr_resp_o.bresp   = ni_pkg::axi_resp_t'(b_head[1:0]);
  end

endmodule

// ==== rtl/axi_rd_ctrl.sv ====
/*
  Read side of the AXI slave.
  AR requests are decoded and queued; the head request streams flits
  from its receive buffer as R beats, or one SLVERR beat on error.
*/
`timescale 1ns/1ps
`include "ni_cfg.svh"

module axi_rd_ctrl (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  input  ni_pkg::axi_req_t      axi_req_i,
  output ni_pkg::axi_resp_bus_t rd_resp_o,
  output logic [`NI_VC_W-1:0]   buf_vc_o,
  output logic                  buf_pop_o,
  input  logic [`NI_DATA_W-1:0] buf_flit_i,
  input  logic                  buf_empty_i
);
  ni_pkg::region_t      ar_region;
  logic [`NI_VC_W-1:0]  ar_vc;
  ni_pkg::ot_entry_t    ot_in;
  ni_pkg::ot_entry_t    ot_head;
  logic                 ot_full;
  logic                 ot_empty;
  logic                 ar_hs;
  logic                 active_q;
  logic                 active_d;
  logic [`NI_LEN_W-1:0] beat_q;
  logic [`NI_LEN_W-1:0] beat_d;
  logic                 rd_good;
  logic                 r_valid;
  logic                 r_last;
  logic                 r_hs;
  logic                 r_done;

  // ********************
  // address channel
  mm_region_decode u_ar_decode (
    .addr_i   (axi_req_i.araddr),
    .burst_i  (axi_req_i.arburst),
    .size_i   (axi_req_i.arsize),
    .region_o (ar_region),
    .vc_o     (ar_vc)
  );

  assign ar_hs = axi_req_i.arvalid && !ot_full;

  always_comb begin
    ot_in.id     = axi_req_i.arid;
    ot_in.len    = axi_req_i.arlen;
    ot_in.region = ar_region;
    ot_in.vc     = ar_vc;
  end

  // outstanding reads, retired on the rlast beat
  sync_fifo #(
    .DEPTH (`NI_OT_DEPTH),
    .WIDTH ($bits(ni_pkg::ot_entry_t))
  ) u_rd_ot_fifo (
    .clk_axi  (clk_axi),
    .arst_axi (arst_axi),
    .push_i   (ar_hs),
    .pop_i    (r_done),
    .data_i   (ot_in),
    .data_o   (ot_head),
    .full_o   (ot_full),
    .empty_o  (ot_empty)
  );

  // ********************
  // data channel
  assign rd_good  = (ot_head.region == ni_pkg::REGION_RD_VC);
  assign buf_vc_o = ot_head.vc;

  // good read waits for buffer data, error read fires at once
  assign r_valid = active_q && (rd_good ? !buf_empty_i : 1'b1);
  // error read is a single beat
  assign r_last  = r_valid && (rd_good ? (beat_q == ot_head.len) : 1'b1);
  assign r_hs    = r_valid && axi_req_i.rready;
  assign r_done  = r_hs && r_last;

  // buffer head advances only on a real transfer
  assign buf_pop_o = r_hs && rd_good;

  // head tracking, one cycle to pick up a new request
  always_comb begin
    active_d = active_q;
    beat_d   = beat_q;
    if (!active_q) begin
      active_d = !ot_empty;
      beat_d   = '0;
    end else if (r_hs) begin
      if (r_last) begin
        active_d = 1'b0;
        beat_d   = '0;
      end else begin
        beat_d = beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      active_q <= 1'b0;
      beat_q   <= '0;
    end else begin
      active_q <= active_d;
      beat_q   <= beat_d;
    end
  end

  // ar and r fields only
  always_comb begin
    rd_resp_o         = '0;
    rd_resp_o.arready = !ot_full;
    rd_resp_o.rvalid  = r_valid;
    rd_resp_o.rid     = ot_head.id;
    rd_resp_o.rdata   = rd_good ? buf_flit_i : '0;
    rd_resp_o.rresp   = rd_good ? ni_pkg::RESP_OKAY : ni_pkg::RESP_SLVERR;
    rd_resp_o.rlast   = r_last;
  end

endmodule

// ==== rtl/rx_vc_buffers.sv ====
/*
  Receive buffers, one FIFO per virtual channel.
  Incoming flits go to the FIFO of their channel; the read side
  picks one channel and sees its head and empty flag.
*/
`timescale 1ns/1ps
`include "ni_cfg.svh"

module rx_vc_buffers (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  input  ni_pkg::flit_in_t      pkt_in_i,
  output logic                  pkt_in_ready_o,
  input  logic [`NI_VC_W-1:0]   rd_vc_i,
  input  logic                  rd_pop_i,
  output logic [`NI_DATA_W-1:0] rd_flit_o,
  output logic                  rd_empty_o
);
  logic [`NI_NUM_VC-1:0]                 vc_push;
  logic [`NI_NUM_VC-1:0]                 vc_pop;
  logic [`NI_NUM_VC-1:0]                 vc_full;
  logic [`NI_NUM_VC-1:0]                 vc_empty;
  logic [`NI_NUM_VC-1:0][`NI_DATA_W-1:0] vc_head;

  // back-pressure from the addressed buffer only
  assign pkt_in_ready_o = !vc_full[pkt_in_i.vc];

  for (genvar g = 0; g < `NI_NUM_VC; g++) begin : gen_vc_buf
    // steer by channel tag
    assign vc_push[g] = pkt_in_i.valid && (pkt_in_i.vc == `NI_VC_W'(g)) && !vc_full[g];
    assign vc_pop[g]  = rd_pop_i && (rd_vc_i == `NI_VC_W'(g));

    sync_fifo #(
      .DEPTH (`NI_RXBUF_DEPTH),
      .WIDTH (`NI_DATA_W)
    ) u_vc_fifo (
      .clk_axi  (clk_axi),
      .arst_axi (arst_axi),
      .push_i   (vc_push[g]),
      .pop_i    (vc_pop[g]),
      .data_i   (pkt_in_i.flit),
      .data_o   (vc_head[g]),
      .full_o   (vc_full[g]),
      .empty_o  (vc_empty[g])
    );
  end

  // read side mux
  assign rd_flit_o  = vc_head[rd_vc_i];
  assign rd_empty_o = vc_empty[rd_vc_i];

endmodule

// ==== rtl/axi_slave_ni.sv ====
/*
  AXI4 slave network interface, top level.
  Write bursts become flits on packet-out; flits from packet-in are
  buffered per channel and returned by read bursts.
*/
`timescale 1ns/1ps
`include "ni_cfg.svh"

module axi_slave_ni (
  input  logic                  clk_axi,
  input  logic                  arst_axi,
  input  ni_pkg::axi_req_t      axi_req_i,
  output ni_pkg::axi_resp_bus_t axi_resp_o,
  output ni_pkg::flit_out_t     pkt_out_o,
  input  logic                  pkt_out_ready_i,
  input  ni_pkg::flit_in_t      pkt_in_i,
  output logic                  pkt_in_ready_o
);
  ni_pkg::axi_resp_bus_t wr_resp;
  ni_pkg::axi_resp_bus_t rd_resp;
  logic [`NI_VC_W-1:0]   buf_vc;
  logic                  buf_pop;
  logic [`NI_DATA_W-1:0] buf_flit;
  logic                  buf_empty;

  // ********************
  // write path to the router
  axi_wr_ctrl u_axi_wr_ctrl (
    .clk_axi         (clk_axi),
    .arst_axi        (arst_axi),
    .axi_req_i       (axi_req_i),
    .wr_resp_o       (wr_resp),
    .pkt_out_o       (pkt_out_o),
    .pkt_out_ready_i (pkt_out_ready_i)
  );

  // ********************
  // read path from the router
  axi_rd_ctrl u_axi_rd_ctrl (
    .clk_axi     (clk_axi),
    .arst_axi    (arst_axi),
    .axi_req_i   (axi_req_i),
    .rd_resp_o   (rd_resp),
    .buf_vc_o    (buf_vc),
    .buf_pop_o   (buf_pop),
    .buf_flit_i  (buf_flit),
    .buf_empty_i (buf_empty)
  );

  rx_vc_buffers u_rx_vc_buffers (
    .clk_axi        (clk_axi),
    .arst_axi       (arst_axi),
    .pkt_in_i       (pkt_in_i),
    .pkt_in_ready_o (pkt_in_ready_o),
    .rd_vc_i        (buf_vc),
    .rd_pop_i       (buf_pop),
    .rd_flit_o      (buf_flit),
    .rd_empty_o     (buf_empty)
  );

  // each controller owns its own channels
  always_comb begin
    axi_resp_o         = rd_resp;
    axi_resp_o.awready = wr_resp.awready;
    axi_resp_o.wready  = wr_resp.wready;
    axi_resp_o.bvalid  = wr_resp.bvalid;
    axi_resp_o.bid     = wr_resp.bid;
    axi_resp_o.bresp   = wr_resp.bresp;
  end

endmodule

// ==== verification/ni_checker.sv ====
/*
  Scoreboard of the network interface testbench.
  The testbench queues expected flits, write responses and read beats;
  each transfer on the DUT ports is compared with the queue head.
*/
`timescale 1ns/1ps
`include "ni_cfg.svh"

module ni_checker (
  input logic                  clk_axi,
  input logic                  arst_axi,
  input ni_pkg::axi_req_t      axi_req_i,
  input ni_pkg::axi_resp_bus_t axi_resp_i,
  input ni_pkg::flit_out_t     pkt_out_i,
  input logic                  pkt_out_ready_i,
  input ni_pkg::flit_in_t      pkt_in_i,
  input logic                  pkt_in_ready_i
);
  // expected write response
  typedef struct packed {
    logic [`NI_ID_W-1:0] id;
    logic [1:0]          resp;
  } b_exp_t;

  // expected read beat
  typedef struct packed {
    logic [`NI_ID_W-1:0]   id;
    logic [`NI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } r_exp_t;

  ni_pkg::flit_out_t flit_q [$];
  b_exp_t            b_q [$];
  r_exp_t            r_q [$];
  int                flit_errs = 0;
  int                b_errs = 0;
  int                r_errs = 0;
  int                other_errs = 0;

  // ********************
  // queue fill, called from the testbench
  task automatic expect_flit(input logic [`NI_VC_W-1:0] vc, input logic [`NI_DATA_W-1:0] data);
    ni_pkg::flit_out_t e;
    e.valid = 1'b1;
    e.vc    = vc;
    e.flit  = data;
    flit_q.push_back(e);
  endtask

  task automatic expect_b(input logic [`NI_ID_W-1:0] id, input logic [1:0] resp);
    b_exp_t e;
    e.id   = id;
    e.resp = resp;
    b_q.push_back(e);
  endtask

  task automatic expect_r(input logic [`NI_ID_W-1:0] id, input logic [`NI_DATA_W-1:0] data,
                          input logic [1:0] resp, input logic last);
    r_exp_t e;
    e.id   = id;
    e.data = data;
    e.resp = resp;
    e.last = last;
    r_q.push_back(e);
  endtask

  // ********************
  // comparison and bookkeeping
  // cat: 0 flit, 1 write response, 2 read beat, 3 anything else
  task automatic compare(input string name, input logic [31:0] exp_v,
                         input logic [31:0] act_v, input int cat);
    if (exp_v !== act_v) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
      case (cat)
        0:       flit_errs = flit_errs + 1;
        1:       b_errs = b_errs + 1;
        2:       r_errs = r_errs + 1;
        default: other_errs = other_errs + 1;
      endcase
    end
  endtask

  task automatic note_error(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    other_errs = other_errs + 1;
  endtask

  // ready of the channel currently on pkt_in_i.vc
  task automatic check_in_ready(input logic exp_ready);
    compare($sformatf("pkt_in_ready_o (vc %0d)", pkt_in_i.vc), 32'(exp_ready),
            32'(pkt_in_ready_i), 3);
  endtask

  function automatic int pending();
    return flit_q.size() + b_q.size() + r_q.size();
  endfunction

  function automatic int total_errors();
    return flit_errs + b_errs + r_errs + other_errs;
  endfunction

  task automatic report();
    $display("errors: pkt_out %0d, b %0d, r %0d, other %0d, total %0d",
             flit_errs, b_errs, r_errs, other_errs, total_errors());
  endtask

  // ********************
  // per-channel checks
  task automatic check_flit();
    ni_pkg::flit_out_t e;
    if (flit_q.size() == 0) begin
      note_error("flit sent on pkt_out although none was expected");
    end else begin
      e = flit_q.pop_front();
      compare("pkt_out_o.vc", 32'(e.vc), 32'(pkt_out_i.vc), 0);
      compare("pkt_out_o.flit", e.flit, pkt_out_i.flit, 0);
    end
  endtask

  task automatic check_b();
    b_exp_t e;
    if (b_q.size() == 0) begin
      note_error("write response sent although none was expected");
    end else begin
      e = b_q.pop_front();
      compare("axi_resp_o.bid", 32'(e.id), 32'(axi_resp_i.bid), 1);
      compare("axi_resp_o.bresp", 32'(e.resp), 32'(axi_resp_i.bresp), 1);
    end
  endtask

  task automatic check_r();
    r_exp_t e;
    if (r_q.size() == 0) begin
      note_error("read beat sent although none was expected");
    end else begin
      e = r_q.pop_front();
      compare("axi_resp_o.rid", 32'(e.id), 32'(axi_resp_i.rid), 2);
      compare("axi_resp_o.rdata", e.data, axi_resp_i.rdata, 2);
      compare("axi_resp_o.rresp", 32'(e.resp), 32'(axi_resp_i.rresp), 2);
      compare("axi_resp_o.rlast", 32'(e.last), 32'(axi_resp_i.rlast), 2);
    end
  endtask

  // mid-cycle sampling, the transfer itself happens on the next rising edge
  always @(negedge clk_axi) begin
    if (!arst_axi) begin
      if (pkt_out_i.valid && pkt_out_ready_i) begin
        check_flit();
      end
      if (axi_resp_i.bvalid && axi_req_i.bready) begin
        check_b();
      end
      if (axi_resp_i.rvalid && axi_req_i.rready) begin
        check_r();
      end
    end
  end

endmodule

// ==== verification/tb_axi_slave_ni.sv ====
/*
  Testbench of the AXI slave network interface.
  Runs the records of ni_patterns.txt against the DUT, with random
  stalls on the ready inputs; ni_checker does the comparing.
*/
`timescale 1ns/1ps
`include "ni_cfg.svh"

module tb_axi_slave_ni;
  localparam int PAT_DEPTH = 128;
  // record ops
  localparam logic [3:0] OP_WRITE = 4'h1;
  localparam logic [3:0] OP_WBEAT = 4'h2;
  localparam logic [3:0] OP_FLIT  = 4'h3;
  localparam logic [3:0] OP_READ  = 4'h5;
  localparam logic [3:0] OP_RBEAT = 4'h6;
  localparam logic [3:0] OP_FILL  = 4'h7;
  // handshake selects
  localparam int CH_AW     = 0;
  localparam int CH_W      = 1;
  localparam int CH_AR     = 2;
  localparam int CH_PKT_IN = 3;

  logic                  clk_axi = 1'b0;
  logic                  arst_axi;
  ni_pkg::axi_req_t      axi_req;
  ni_pkg::axi_resp_bus_t axi_resp;
  ni_pkg::flit_out_t     pkt_out;
  logic                  pkt_out_ready;
  ni_pkg::flit_in_t      pkt_in;
  logic                  pkt_in_ready;
  // one hex nibble per record column
  // [63:60] op [59:56] id [53:52] burst [50:48] size [45:44] resp
  // [43:40] vc [39:32] len [31:0] data, or address in [15:0]
  logic [63:0]           pat_mem [PAT_DEPTH];
  int                    rec_cnt = 0;
  integer                seed = 32'h4202;
  int                    p;

  always #20 clk_axi = ~clk_axi;

  axi_slave_ni i_axi_slave_ni (
    .clk_axi         (clk_axi),
    .arst_axi        (arst_axi),
    .axi_req_i       (axi_req),
    .axi_resp_o      (axi_resp),
    .pkt_out_o       (pkt_out),
    .pkt_out_ready_i (pkt_out_ready),
    .pkt_in_i        (pkt_in),
    .pkt_in_ready_o  (pkt_in_ready)
  );

  ni_checker i_ni_checker (
    .clk_axi         (clk_axi),
    .arst_axi        (arst_axi),
    .axi_req_i       (axi_req),
    .axi_resp_i      (axi_resp),
    .pkt_out_i       (pkt_out),
    .pkt_out_ready_i (pkt_out_ready),
    .pkt_in_i        (pkt_in),
    .pkt_in_ready_i  (pkt_in_ready)
  );

  // ********************
  // record access
  function automatic logic [3:0] rec_op(input int idx);
    return (idx < PAT_DEPTH) ? pat_mem[idx][63:60] : 4'h0;
  endfunction

  task automatic load_patterns();
    logic [3:0] op;
    for (int i = 0; i < PAT_DEPTH; i++) begin
      pat_mem[i] = '0;
    end
    $readmemh("verification/ni_patterns.txt", pat_mem);
    // count headers only since beat lines belong to their header
    for (int i = 0; i < PAT_DEPTH; i++) begin
      op = rec_op(i);
      if (op == OP_WRITE || op == OP_FLIT || op == OP_READ || op == OP_FILL) begin
        rec_cnt = rec_cnt + 1;
      end
    end
  endtask

  // ********************
  // bus handshakes
  // ready is looked at mid-cycle and the transfer lands on the next edge
  task automatic wait_handshake(input int chan);
    logic rdy;
    do begin
      @(negedge clk_axi);
      case (chan)
        CH_AW:   rdy = axi_resp.awready;
        CH_W:    rdy = axi_resp.wready;
        CH_AR:   rdy = axi_resp.arready;
        default: rdy = pkt_in_ready;
      endcase
    end while (!rdy);
    @(posedge clk_axi);
    #2;
  endtask

  task automatic send_w(input logic [`NI_DATA_W-1:0] data, input logic last);
    axi_req.wdata  = data;
    axi_req.wlast  = last;
    axi_req.wvalid = 1'b1;
    wait_handshake(CH_W);
    axi_req.wvalid = 1'b0;
    axi_req.wlast  = 1'b0;
  endtask

  task automatic send_flit(input logic [`NI_VC_W-1:0] vc, input logic [`NI_DATA_W-1:0] data);
    pkt_in.vc    = vc;
    pkt_in.flit  = data;
    pkt_in.valid = 1'b1;
    wait_handshake(CH_PKT_IN);
    pkt_in.valid = 1'b0;
  endtask

  // until every queued expectation has been seen
  task automatic wait_quiet();
    do begin
      @(negedge clk_axi);
    end while (i_ni_checker.pending() != 0);
    @(posedge clk_axi);
    #2;
  endtask

  // ********************
  // record runners
  task automatic run_write(inout int idx);
    logic [63:0] hdr;
    int          first;
    hdr   = pat_mem[idx];
    idx   = idx + 1;
    first = idx;
    i_ni_checker.expect_b(hdr[59:56], hdr[45:44]);
    // flits only for a good write
    while (rec_op(idx) == OP_WBEAT) begin
      if (hdr[45:44] == 2'b00) begin
        i_ni_checker.expect_flit(pat_mem[idx][40 +: `NI_VC_W], pat_mem[idx][31:0]);
      end
      idx = idx + 1;
    end
    axi_req.awid    = hdr[59:56];
    axi_req.awburst = ni_pkg::axi_burst_t'(hdr[53:52]);
    axi_req.awsize  = hdr[50:48];
    axi_req.awlen   = hdr[39:32];
    axi_req.awaddr  = hdr[15:0];
    axi_req.awvalid = 1'b1;
    wait_handshake(CH_AW);
    axi_req.awvalid = 1'b0;
    for (int i = first; i < idx; i++) begin
      send_w(pat_mem[i][31:0], i == idx - 1);
    end
  endtask

  task automatic run_read(inout int idx);
    logic [63:0] hdr;
    hdr = pat_mem[idx];
    idx = idx + 1;
    // last expected line carries rlast
    while (rec_op(idx) == OP_RBEAT) begin
      i_ni_checker.expect_r(hdr[59:56], pat_mem[idx][31:0], hdr[45:44],
                            rec_op(idx + 1) != OP_RBEAT);
      idx = idx + 1;
    end
    axi_req.arid    = hdr[59:56];
    axi_req.arburst = ni_pkg::axi_burst_t'(hdr[53:52]);
    axi_req.arsize  = hdr[50:48];
    axi_req.arlen   = hdr[39:32];
    axi_req.araddr  = hdr[15:0];
    axi_req.arvalid = 1'b1;
    wait_handshake(CH_AR);
    axi_req.arvalid = 1'b0;
  endtask

  // fills one receive buffer and then looks at ready for both channels
  task automatic fill_channel(input logic [63:0] rec);
    logic [`NI_VC_W-1:0] vc;
    vc = rec[40 +: `NI_VC_W];
    for (int i = 0; i < `NI_RXBUF_DEPTH; i++) begin
      send_flit(vc, rec[31:0] + 32'(i));
    end
    @(negedge clk_axi);
    i_ni_checker.check_in_ready(1'b0);
    @(posedge clk_axi);
    #2;
    pkt_in.vc = vc + 1'b1;
    @(negedge clk_axi);
    i_ni_checker.check_in_ready(1'b1);
    @(posedge clk_axi);
    #2;
  endtask

  // ********************
  // random back-pressure on the ready inputs
  always begin
    @(posedge clk_axi);
    #2;
    pkt_out_ready  = ($random(seed) & 3) != 0;
    axi_req.bready = ($random(seed) & 3) != 0;
    axi_req.rready = ($random(seed) & 3) != 0;
  end

  // watchdog sized by the record count
  initial begin
    @(negedge arst_axi);
    repeat ((rec_cnt + 1) * 200) @(posedge clk_axi);
    $display("timeout: the run did not finish within %0d cycles", (rec_cnt + 1) * 200);
    i_ni_checker.report();
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    axi_req       = '0;
    pkt_in        = '0;
    pkt_out_ready = 1'b0;
    arst_axi      = 1'b1;
    load_patterns();
    if (rec_cnt == 0) begin
      i_ni_checker.note_error("no records found in the pattern file");
    end
    repeat (16) @(posedge clk_axi);
    #2;
    arst_axi = 1'b0;
    p = 0;
    while (rec_op(p) != 4'h0) begin
      case (rec_op(p))
        OP_WRITE: run_write(p);
        OP_READ:  run_read(p);
        OP_FLIT: begin
          send_flit(pat_mem[p][40 +: `NI_VC_W], pat_mem[p][31:0]);
          p = p + 1;
        end
        OP_FILL: begin
          wait_quiet();
          fill_channel(pat_mem[p]);
          p = p + 1;
        end
        default: begin
          i_ni_checker.note_error($sformatf("record line %0d has an unknown op", p));
          p = p + 1;
        end
      endcase
    end
    wait_quiet();
    repeat (4) @(posedge clk_axi);
    i_ni_checker.report();
    if (i_ni_checker.total_errors() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/ni_patterns.txt ====
// op id burst size resp vc len data; data holds the address on write and read headers
// op 1 write, 2 write beat, 3 flit in, 5 read, 6 expected read beat, 7 fill channel
// write burst to vc0
1_1_1_2_0_0_03_00001000
2_0_0_0_0_0_00_a0000000
2_0_0_0_0_0_00_a0000001
2_0_0_0_0_0_00_a0000002
2_0_0_0_0_0_00_a0000003
// write burst to vc1
1_2_1_2_0_0_01_00001008
2_0_0_0_0_1_00_b0000000
2_0_0_0_0_1_00_b0000001
// address between the windows, fixed burst, narrow beats
1_3_1_2_2_0_01_00001004
2_0_0_0_0_0_00_deadbee0
2_0_0_0_0_0_00_deadbee1
1_4_0_2_2_0_00_00001000
2_0_0_0_0_0_00_deadbee2
1_5_1_1_2_0_01_00001008
2_0_0_0_0_0_00_deadbee3
2_0_0_0_0_0_00_deadbee4
// good write after the errors
1_6_1_2_0_0_02_00001008
2_0_0_0_0_1_00_b0000010
2_0_0_0_0_1_00_b0000011
2_0_0_0_0_1_00_b0000012
// flits from the network
3_0_0_0_0_0_00_c0000001
3_0_0_0_0_0_00_c0000002
3_0_0_0_0_0_00_c0000003
3_0_0_0_0_1_00_d0000001
// reads of vc0 and vc1
5_7_1_2_0_0_02_00002000
6_0_0_0_0_0_00_c0000001
6_0_0_0_0_0_00_c0000002
6_0_0_0_0_0_00_c0000003
5_8_1_2_0_0_00_00002008
6_0_0_0_0_0_00_d0000001
// bad address read and wrap read, one zero beat each
5_9_1_2_2_0_03_00002004
6_0_0_0_0_0_00_00000000
5_a_2_2_2_0_01_00002000
6_0_0_0_0_0_00_00000000
// fill vc1, then drain it
7_0_0_0_0_1_00_e0000000
5_b_1_2_0_0_07_00002008
6_0_0_0_0_0_00_e0000000
6_0_0_0_0_0_00_e0000001
6_0_0_0_0_0_00_e0000002
6_0_0_0_0_0_00_e0000003
6_0_0_0_0_0_00_e0000004
6_0_0_0_0_0_00_e0000005
6_0_0_0_0_0_00_e0000006
6_0_0_0_0_0_00_e0000007

// ==== project.f ====
+incdir+rtl
rtl/ni_pkg.sv
rtl/sync_fifo.sv
rtl/mm_region_decode.sv
rtl/axi_wr_ctrl.sv
rtl/axi_rd_ctrl.sv
rtl/rx_vc_buffers.sv
rtl/axi_slave_ni.sv
verification/ni_checker.sv
verification/tb_axi_slave_ni.sv

// ==== Bender.yml ====
package:
  name: axi_slave_ni

export_include_dirs:
  - rtl

sources:
  - rtl/ni_pkg.sv
  - rtl/sync_fifo.sv
  - rtl/mm_region_decode.sv
  - rtl/axi_wr_ctrl.sv
  - rtl/axi_rd_ctrl.sv
  - rtl/rx_vc_buffers.sv
  - rtl/axi_slave_ni.sv
  - target: test
    files:
      - verification/ni_checker.sv
      - verification/tb_axi_slave_ni.sv
